/* source/cache_pkg.sv */
// cache geometry and request encodings shared by the cache RTL and its testbench
// referenced with scoped names, for example cache_pkg::tag_width
package cache_pkg;

  // address layout from bit 0 upward is byte select, word, index, tag
  localparam int addr_width = 16;
  localparam int data_width = 32;
  localparam int ways = 2;
  localparam int sets = 16;
  localparam int block_words = 4;
  localparam int byte_sel_width = 2;
  localparam int word_sel_width = 2;
  localparam int index_width = 4;
  localparam int tag_width = 8;
  localparam int id_width = 4;
  localparam int mask_width = 4;

  typedef enum logic [2:0] {
    op_ld,
    op_st,
    op_block_ld,
    op_tag_st
  } req_op_e;

  // encoded as log2 of the access size in bytes
  typedef enum logic [1:0] {
    size_byte,
    size_half,
    size_word
  } size_e;

endpackage

/* source/cache_mem_pkg.sv */
// opcodes of the tag and stat memories and the depth of the miss FIFO
// referenced with scoped names such as cache_mem_pkg::tag_store
package cache_mem_pkg;

  typedef enum logic {
    tag_read,
    tag_store
  } tag_op_e;

  // stat_read means no update, the read itself is requested by the strobe
  typedef enum logic [1:0] {
    stat_read,
    stat_set_lru,
    stat_set_lru_and_dirty
  } stat_op_e;

  localparam int miss_fifo_depth = 4;

endpackage

/* source/cache_tag_mem.sv */
// tags and valid bits of both ways, one read of a whole set per access
// a store writes one way, the read outputs hold until the next read
`timescale 1ns/1ns

module cache_tag_mem (
  input  logic                                                   clk_i,
  input  logic                                                   reset_i,
  input  logic                                                   v_i,
  input  cache_mem_pkg::tag_op_e                                 op_i,
  input  logic [cache_pkg::index_width-1:0]                      index_i,
  input  logic [$clog2(cache_pkg::ways)-1:0]                     way_i,
  input  logic [cache_pkg::tag_width-1:0]                        tag_i,
  input  logic                                                   valid_i,
  output logic [cache_pkg::ways-1:0][cache_pkg::tag_width-1:0]   tag_o,
  output logic [cache_pkg::ways-1:0]                             valid_o
);

  logic [cache_pkg::tag_width-1:0] tag_r [cache_pkg::ways][cache_pkg::sets];
  logic [cache_pkg::sets-1:0][cache_pkg::ways-1:0] valid_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_r <= '0;
      valid_o <= '0;
    end else if (v_i) begin
      if (op_i == cache_mem_pkg::tag_store)
        valid_r[index_i][way_i] <= valid_i;
      else
        valid_o <= valid_r[index_i];
    end
  end

  always_ff @(posedge clk_i) begin
    if (v_i) begin
      if (op_i == cache_mem_pkg::tag_store) begin
        tag_r[way_i][index_i] <= tag_i;
      end else begin
        for (int w = 0; w < cache_pkg::ways; w++)
          tag_o[w] <= tag_r[w][index_i];
      end
    end
  end

endmodule

/* source/cache_stat_mem.sv */
// per-set LRU bit and per-way dirty bits, read together with the tags
// an update to the set being read in the same cycle is forwarded into the result
`timescale 1ns/1ns

module cache_stat_mem (
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  logic                                v_i,
  input  cache_mem_pkg::stat_op_e             op_i,
  input  logic [cache_pkg::index_width-1:0]   rd_index_i,
  input  logic [cache_pkg::index_width-1:0]   wr_index_i,
  input  logic [$clog2(cache_pkg::ways)-1:0]  way_i,
  output logic [$clog2(cache_pkg::ways)-1:0]  lru_o,
  output logic [cache_pkg::ways-1:0]          dirty_o
);

  logic [cache_pkg::sets-1:0][$clog2(cache_pkg::ways)-1:0] lru_r;
  logic [cache_pkg::sets-1:0][cache_pkg::ways-1:0] dirty_r;
  logic update;
  logic same_set;
  logic [cache_pkg::ways-1:0] dirty_set;
  logic [$clog2(cache_pkg::ways)-1:0] lru_new;

  assign update = (op_i != cache_mem_pkg::stat_read);
  assign same_set = update && (rd_index_i == wr_index_i);

  // with two ways the next victim is simply the way that was not hit
  assign lru_new = ~way_i;
  assign dirty_set = (op_i == cache_mem_pkg::stat_set_lru_and_dirty)
    ? (cache_pkg::ways)'(1) << way_i
    : '0;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      lru_r <= '0;
      dirty_r <= '0;
      lru_o <= '0;
      dirty_o <= '0;
    end else begin
      if (update) begin
        lru_r[wr_index_i] <= lru_new;
        dirty_r[wr_index_i] <= dirty_r[wr_index_i] | dirty_set;
      end
      if (v_i) begin
        lru_o <= same_set ? lru_new : lru_r[rd_index_i];
        dirty_o <= dirty_r[rd_index_i] | (same_set ? dirty_set : '0);
      end
    end
  end

endmodule

/* source/cache_data_mem.sv */
// data words of both ways, one access per cycle
// stores are byte masked, loads come back aligned to bit 0 one cycle later
`timescale 1ns/1ns

module cache_data_mem (
  input  logic                                                     clk_i,
  input  logic                                                     v_i,
  input  logic                                                     we_i,
  input  logic [$clog2(cache_pkg::ways)-1:0]                       way_i,
  input  logic [cache_pkg::index_width+cache_pkg::word_sel_width-1:0] addr_i,
  input  cache_pkg::size_e                                         size_i,
  input  logic                                                     sigext_i,
  input  logic [cache_pkg::byte_sel_width-1:0]                     byte_sel_i,
  input  logic [cache_pkg::mask_width-1:0]                         mask_i,
  input  logic [cache_pkg::data_width-1:0]                         wdata_i,
  output logic [cache_pkg::data_width-1:0]                         rdata_o
);

  logic [cache_pkg::data_width-1:0] mem_r
    [cache_pkg::ways*cache_pkg::sets*cache_pkg::block_words];
  logic [cache_pkg::data_width-1:0] word;
  logic [cache_pkg::data_width-1:0] shifted;
  logic [cache_pkg::data_width-1:0] load_data;

  // way is the top address bit of the flat array
  assign word = mem_r[{way_i, addr_i}];
  assign shifted = word >> {byte_sel_i, 3'b000};

  always_comb begin
    case (size_i)
      cache_pkg::size_byte: begin
        load_data = {{(cache_pkg::data_width-8){sigext_i & shifted[7]}}, shifted[7:0]};
      end
      cache_pkg::size_half: begin
        load_data = {{(cache_pkg::data_width-16){sigext_i & shifted[15]}}, shifted[15:0]};
      end
      default: begin
        load_data = shifted;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (v_i && we_i) begin
      for (int b = 0; b < cache_pkg::mask_width; b++) begin
        if (mask_i[b])
          mem_r[{way_i, addr_i}][8*b +: 8] <= wdata_i[8*b +: 8];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (v_i && !we_i)
      rdata_o <= load_data;
  end

endmodule

/* source/cache_miss_fifo.sv */
// queue of missed requests waiting for the miss handler outside the cache
// entries leave in order on yumi_i, store data and size ride along for later use
`timescale 1ns/1ns

module cache_miss_fifo (
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  logic                                push_i,
  input  logic [cache_pkg::id_width-1:0]      id_i,
  input  logic [cache_pkg::addr_width-1:0]    addr_i,
  input  cache_pkg::req_op_e                  op_i,
  input  cache_pkg::size_e                    size_i,
  input  logic [cache_pkg::data_width-1:0]    data_i,
  input  logic [$clog2(cache_pkg::ways)-1:0]  way_i,
  input  logic                                dirty_i,
  input  logic                                yumi_i,
  output logic                                full_o,
  output logic                                v_o,
  output logic [cache_pkg::id_width-1:0]      id_o,
  output logic [cache_pkg::addr_width-1:0]    addr_o,
  output cache_pkg::req_op_e                  op_o,
  output logic [$clog2(cache_pkg::ways)-1:0]  way_o,
  output logic                                dirty_o
);

  typedef struct packed {
    logic [cache_pkg::id_width-1:0]     id;
    logic [cache_pkg::addr_width-1:0]   addr;
    cache_pkg::req_op_e                 op;
    cache_pkg::size_e                   size;
    logic [cache_pkg::data_width-1:0]   data;
    logic [$clog2(cache_pkg::ways)-1:0] way;
    logic                               dirty;
  } miss_entry_t;

  miss_entry_t entry_r [cache_mem_pkg::miss_fifo_depth];
  miss_entry_t head;
  logic [$clog2(cache_mem_pkg::miss_fifo_depth)-1:0] wr_ptr_r;
  logic [$clog2(cache_mem_pkg::miss_fifo_depth)-1:0] rd_ptr_r;
  logic [$clog2(cache_mem_pkg::miss_fifo_depth+1)-1:0] count_r;

  assign full_o = (count_r == cache_mem_pkg::miss_fifo_depth);
  assign v_o = (count_r != '0);
  assign head = entry_r[rd_ptr_r];
  assign id_o = head.id;
  assign addr_o = head.addr;
  assign op_o = head.op;
  assign way_o = head.way;
  assign dirty_o = head.dirty;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r <= '0;
    end else begin
      if (push_i)
        wr_ptr_r <= wr_ptr_r + 1'b1;
      if (yumi_i)
        rd_ptr_r <= rd_ptr_r + 1'b1;
      count_r <= count_r + push_i - yumi_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i)
      entry_r[wr_ptr_r] <= '{id_i, addr_i, op_i, size_i, data_i, way_i, dirty_i};
  end

endmodule

/* source/cache_tl_stage.sv */
// tag-lookup stage, the one control block of the cache
// holds the request under lookup and issues data, stat and miss FIFO actions
`timescale 1ns/1ns

module cache_tl_stage (
  input  logic                                                     clk_i,
  input  logic                                                     reset_i,
  input  logic                                                     v_i,
  input  cache_pkg::req_op_e                                       op_i,
  input  logic [cache_pkg::id_width-1:0]                           id_i,
  input  logic [cache_pkg::addr_width-1:0]                         addr_i,
  input  cache_pkg::size_e                                         size_i,
  input  logic                                                     sigext_i,
  input  logic [cache_pkg::data_width-1:0]                         data_i,
  input  logic [cache_pkg::mask_width-1:0]                         mask_i,
  output logic                                                     ready_o,
  // tag memory
  output logic                                                     tag_v_o,
  output cache_mem_pkg::tag_op_e                                   tag_op_o,
  output logic [cache_pkg::index_width-1:0]                        tag_index_o,
  output logic [$clog2(cache_pkg::ways)-1:0]                       tag_way_o,
  output logic [cache_pkg::tag_width-1:0]                          tag_data_o,
  output logic                                                     tag_valid_set_o,
  input  logic [cache_pkg::ways-1:0][cache_pkg::tag_width-1:0]     tag_i,
  input  logic [cache_pkg::ways-1:0]                               valid_i,
  // stat memory
  output logic                                                     stat_v_o,
  output cache_mem_pkg::stat_op_e                                  stat_op_o,
  output logic [cache_pkg::index_width-1:0]                        stat_rd_index_o,
  output logic [cache_pkg::index_width-1:0]                        stat_wr_index_o,
  output logic [$clog2(cache_pkg::ways)-1:0]                       stat_way_o,
  input  logic [$clog2(cache_pkg::ways)-1:0]                       lru_i,
  input  logic [cache_pkg::ways-1:0]                               dirty_i,
  // data memory
  output logic                                                     data_v_o,
  output logic                                                     data_we_o,
  output logic [$clog2(cache_pkg::ways)-1:0]                       data_way_o,
  output logic [cache_pkg::index_width+cache_pkg::word_sel_width-1:0] data_addr_o,
  output cache_pkg::size_e                                         data_size_o,
  output logic                                                     data_sigext_o,
  output logic [cache_pkg::byte_sel_width-1:0]                     data_byte_sel_o,
  output logic [cache_pkg::mask_width-1:0]                         data_mask_o,
  output logic [cache_pkg::data_width-1:0]                         data_wdata_o,
  // miss FIFO
  output logic                                                     miss_push_o,
  output logic [cache_pkg::id_width-1:0]                           miss_id_o,
  output logic [cache_pkg::addr_width-1:0]                         miss_addr_o,
  output cache_pkg::req_op_e                                       miss_op_o,
  output logic [$clog2(cache_pkg::ways)-1:0]                       miss_way_o,
  output logic                                                     miss_dirty_o,
  input  logic                                                     miss_full_i,
  // response
  output logic                                                     resp_v_o,
  output logic [cache_pkg::id_width-1:0]                           resp_id_o
);

  logic v_tl_r;
  cache_pkg::req_op_e op_tl_r;
  logic [cache_pkg::id_width-1:0] id_tl_r;
  logic [cache_pkg::addr_width-1:0] addr_tl_r;
  cache_pkg::size_e size_tl_r;
  logic sigext_tl_r;
  logic [cache_pkg::data_width-1:0] data_tl_r;
  logic [cache_pkg::mask_width-1:0] mask_tl_r;
  logic [cache_pkg::word_sel_width-1:0] counter_r;
  logic resp_v_r;
  logic [cache_pkg::id_width-1:0] resp_id_r;

  logic [cache_pkg::index_width-1:0] index_in;
  logic [cache_pkg::index_width-1:0] index_tl;
  logic [cache_pkg::tag_width-1:0] tag_tl;
  logic [cache_pkg::ways-1:0] tag_hit;
  logic [$clog2(cache_pkg::ways)-1:0] hit_way;
  logic hit;
  logic is_block;
  logic counter_max;
  logic ld_st_hit;
  logic block_ld_hit;
  logic tl_miss;
  logic retire;
  logic accept;
  logic resp_v_n;

  assign index_in = addr_i[cache_pkg::byte_sel_width+cache_pkg::word_sel_width +:
                           cache_pkg::index_width];
  assign index_tl = addr_tl_r[cache_pkg::byte_sel_width+cache_pkg::word_sel_width +:
                              cache_pkg::index_width];
  assign tag_tl = addr_tl_r[cache_pkg::addr_width-1 -: cache_pkg::tag_width];

  // lowest matching way wins
  always_comb begin
    hit_way = '0;
    for (int w = cache_pkg::ways - 1; w >= 0; w--) begin
      tag_hit[w] = valid_i[w] && (tag_i[w] == tag_tl);
      if (tag_hit[w])
        hit_way = w[$clog2(cache_pkg::ways)-1:0];
    end
  end

  assign hit = |tag_hit;
  assign is_block = (op_tl_r == cache_pkg::op_block_ld);
  assign counter_max = (counter_r == (cache_pkg::word_sel_width)'(cache_pkg::block_words - 1));
  assign ld_st_hit = v_tl_r && hit &&
    (op_tl_r == cache_pkg::op_ld || op_tl_r == cache_pkg::op_st);
  assign block_ld_hit = v_tl_r && hit && is_block;
  assign tl_miss = v_tl_r && !hit && (op_tl_r != cache_pkg::op_tag_st);

  always_comb begin
    retire = 1'b0;
    data_v_o = 1'b0;
    stat_op_o = cache_mem_pkg::stat_read;
    miss_push_o = 1'b0;
    resp_v_n = 1'b0;
    if (ld_st_hit) begin
      retire = 1'b1;
      data_v_o = 1'b1;
      stat_op_o = (op_tl_r == cache_pkg::op_st) ? cache_mem_pkg::stat_set_lru_and_dirty
                                                : cache_mem_pkg::stat_set_lru;
      resp_v_n = (op_tl_r == cache_pkg::op_ld);
    end else if (block_ld_hit) begin
      // one word per cycle, the LRU moves with the last word
      retire = counter_max;
      data_v_o = 1'b1;
      stat_op_o = counter_max ? cache_mem_pkg::stat_set_lru : cache_mem_pkg::stat_read;
      resp_v_n = 1'b1;
    end else if (tl_miss) begin
      retire = !miss_full_i;
      miss_push_o = !miss_full_i;
    end else begin
      // empty stage, or a tag store that already wrote when it entered
      retire = 1'b1;
    end
  end

  assign ready_o = retire;
  assign accept = v_i && retire;

  // a tag store takes its way from the lowest tag bit of the address,
  // the tag from the low data bits and the valid bit from the top data bit
  assign tag_v_o = accept;
  assign tag_op_o = (op_i == cache_pkg::op_tag_st) ? cache_mem_pkg::tag_store
                                                   : cache_mem_pkg::tag_read;
  assign tag_index_o = index_in;
  assign tag_way_o = addr_i[cache_pkg::addr_width-cache_pkg::tag_width +:
                            $clog2(cache_pkg::ways)];
  assign tag_data_o = data_i[cache_pkg::tag_width-1:0];
  assign tag_valid_set_o = data_i[cache_pkg::data_width-1];

  assign stat_v_o = accept && (op_i != cache_pkg::op_tag_st);
  assign stat_rd_index_o = index_in;
  assign stat_wr_index_o = index_tl;
  assign stat_way_o = hit_way;

  assign data_we_o = (op_tl_r == cache_pkg::op_st);
  assign data_way_o = hit_way;
  assign data_addr_o = {index_tl, is_block ? counter_r
                                           : addr_tl_r[cache_pkg::byte_sel_width +:
                                                       cache_pkg::word_sel_width]};
  assign data_size_o = is_block ? cache_pkg::size_word : size_tl_r;
  assign data_sigext_o = sigext_tl_r;
  assign data_byte_sel_o = is_block ? '0 : addr_tl_r[cache_pkg::byte_sel_width-1:0];
  assign data_mask_o = mask_tl_r;
  assign data_wdata_o = data_tl_r;

  // the victim is the way named by the LRU bit read with the tags
  assign miss_id_o = id_tl_r;
  assign miss_addr_o = addr_tl_r;
  assign miss_op_o = op_tl_r;
  assign miss_way_o = lru_i;
  assign miss_dirty_o = dirty_i[lru_i];

  assign resp_v_o = resp_v_r;
  assign resp_id_o = resp_id_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      v_tl_r <= 1'b0;
      counter_r <= '0;
      resp_v_r <= 1'b0;
    end else begin
      if (retire)
        v_tl_r <= v_i;
      if (block_ld_hit)
        counter_r <= counter_max ? '0 : counter_r + 1'b1;
      resp_v_r <= resp_v_n;
    end
  end

  always_ff @(posedge clk_i) begin
    resp_id_r <= id_tl_r;
    if (accept) begin
      op_tl_r <= op_i;
      id_tl_r <= id_i;
      addr_tl_r <= addr_i;
      size_tl_r <= size_i;
      sigext_tl_r <= sigext_i;
      data_tl_r <= data_i;
      mask_tl_r <= mask_i;
    end
  end

endmodule

/* source/cache_top.sv */
// top level of the cache front end, takes requests and returns load data
// missed requests leave through the miss FIFO ports for an outside handler
`timescale 1ns/1ns

module cache_top (
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  logic                                v_i,
  input  cache_pkg::req_op_e                  op_i,
  input  logic [cache_pkg::id_width-1:0]      id_i,
  input  logic [cache_pkg::addr_width-1:0]    addr_i,
  input  cache_pkg::size_e                    size_i,
  input  logic                                sigext_i,
  input  logic [cache_pkg::data_width-1:0]    data_i,
  input  logic [cache_pkg::mask_width-1:0]    mask_i,
  output logic                                ready_o,
  output logic                                resp_v_o,
  output logic [cache_pkg::id_width-1:0]      resp_id_o,
  output logic [cache_pkg::data_width-1:0]    resp_data_o,
  output logic                                miss_v_o,
  output logic [cache_pkg::id_width-1:0]      miss_id_o,
  output logic [cache_pkg::addr_width-1:0]    miss_addr_o,
  output cache_pkg::req_op_e                  miss_op_o,
  output logic [$clog2(cache_pkg::ways)-1:0]  miss_way_o,
  output logic                                miss_dirty_o,
  input  logic                                miss_yumi_i
);

  logic tag_v;
  cache_mem_pkg::tag_op_e tag_op;
  logic [cache_pkg::index_width-1:0] tag_index;
  logic [$clog2(cache_pkg::ways)-1:0] tag_way;
  logic [cache_pkg::tag_width-1:0] tag_data;
  logic tag_valid_set;
  logic [cache_pkg::ways-1:0][cache_pkg::tag_width-1:0] tag_rd;
  logic [cache_pkg::ways-1:0] valid_rd;

  logic stat_v;
  cache_mem_pkg::stat_op_e stat_op;
  logic [cache_pkg::index_width-1:0] stat_rd_index;
  logic [cache_pkg::index_width-1:0] stat_wr_index;
  logic [$clog2(cache_pkg::ways)-1:0] stat_way;
  logic [$clog2(cache_pkg::ways)-1:0] lru_rd;
  logic [cache_pkg::ways-1:0] dirty_rd;

  logic data_v;
  logic data_we;
  logic [$clog2(cache_pkg::ways)-1:0] data_way;
  logic [cache_pkg::index_width+cache_pkg::word_sel_width-1:0] data_addr;
  cache_pkg::size_e data_size;
  logic data_sigext;
  logic [cache_pkg::byte_sel_width-1:0] data_byte_sel;
  logic [cache_pkg::data_width-1:0] data_wdata;
  logic [cache_pkg::mask_width-1:0] data_mask;

  logic miss_push;
  logic miss_full;
  logic [cache_pkg::id_width-1:0] push_id;
  logic [cache_pkg::addr_width-1:0] push_addr;
  cache_pkg::req_op_e push_op;
  logic [$clog2(cache_pkg::ways)-1:0] push_way;
  logic push_dirty;

  cache_tl_stage tl (
    .clk_i, .reset_i, .v_i, .op_i, .id_i, .addr_i, .size_i, .sigext_i, .data_i, .mask_i,
    .ready_o,
    .tag_v_o(tag_v), .tag_op_o(tag_op), .tag_index_o(tag_index), .tag_way_o(tag_way),
    .tag_data_o(tag_data), .tag_valid_set_o(tag_valid_set),
    .tag_i(tag_rd), .valid_i(valid_rd),
    .stat_v_o(stat_v), .stat_op_o(stat_op), .stat_rd_index_o(stat_rd_index),
    .stat_wr_index_o(stat_wr_index), .stat_way_o(stat_way),
    .lru_i(lru_rd), .dirty_i(dirty_rd),
    .data_v_o(data_v), .data_we_o(data_we), .data_way_o(data_way), .data_addr_o(data_addr),
    .data_size_o(data_size), .data_sigext_o(data_sigext), .data_byte_sel_o(data_byte_sel),
    .data_mask_o(data_mask), .data_wdata_o(data_wdata),
    .miss_push_o(miss_push), .miss_id_o(push_id), .miss_addr_o(push_addr),
    .miss_op_o(push_op), .miss_way_o(push_way), .miss_dirty_o(push_dirty),
    .miss_full_i(miss_full),
    .resp_v_o, .resp_id_o
  );

  cache_tag_mem tag_mem (
    .clk_i, .reset_i, .v_i(tag_v), .op_i(tag_op), .index_i(tag_index), .way_i(tag_way),
    .tag_i(tag_data), .valid_i(tag_valid_set), .tag_o(tag_rd), .valid_o(valid_rd)
  );

  cache_stat_mem stat_mem (
    .clk_i, .reset_i, .v_i(stat_v), .op_i(stat_op), .rd_index_i(stat_rd_index),
    .wr_index_i(stat_wr_index), .way_i(stat_way), .lru_o(lru_rd), .dirty_o(dirty_rd)
  );

  cache_data_mem data_mem (
    .clk_i, .v_i(data_v), .we_i(data_we), .way_i(data_way), .addr_i(data_addr),
    .size_i(data_size), .sigext_i(data_sigext), .byte_sel_i(data_byte_sel),
    .mask_i(data_mask), .wdata_i(data_wdata), .rdata_o(resp_data_o)
  );

  // store data and access size reach the FIFO through the data memory controls
  cache_miss_fifo miss_fifo (
    .clk_i, .reset_i, .push_i(miss_push), .id_i(push_id), .addr_i(push_addr),
    .op_i(push_op), .size_i(data_size), .data_i(data_wdata), .way_i(push_way),
    .dirty_i(push_dirty), .yumi_i(miss_yumi_i), .full_o(miss_full), .v_o(miss_v_o),
    .id_o(miss_id_o), .addr_o(miss_addr_o), .op_o(miss_op_o), .way_o(miss_way_o),
    .dirty_o(miss_dirty_o)
  );

endmodule

/* tb/cache_tb.sv */
// testbench for the cache front end that replays requests from tb/cache_vectors.txt
// responses are checked in order as they appear and miss entries as they are popped
`timescale 1ns/1ns

module cache_tb;

  // one line of the vector file with the expected words or the miss way and dirty bit in exp
  typedef struct packed {
    logic [31:0] op;
    logic [31:0] id;
    logic [31:0] addr;
    logic [31:0] size;
    logic [31:0] sigext;
    logic [31:0] data;
    logic [31:0] mask;
    logic [31:0] pop;
    logic [31:0] kind;
    logic [3:0][31:0] exp;
  } vector_t;

  typedef struct packed {
    logic [cache_pkg::id_width-1:0] id;
    logic [cache_pkg::data_width-1:0] data;
  } resp_exp_t;

  typedef struct packed {
    logic [cache_pkg::id_width-1:0] id;
    logic [cache_pkg::addr_width-1:0] addr;
    logic [2:0] op;
    logic way;
    logic dirty;
  } miss_exp_t;

  logic clk_i;
  logic reset_i;
  logic v_i;
  cache_pkg::req_op_e op_i;
  logic [cache_pkg::id_width-1:0] id_i;
  logic [cache_pkg::addr_width-1:0] addr_i;
  cache_pkg::size_e size_i;
  logic sigext_i;
  logic [cache_pkg::data_width-1:0] data_i;
  logic [cache_pkg::mask_width-1:0] mask_i;
  logic ready_o;
  logic resp_v_o;
  logic [cache_pkg::id_width-1:0] resp_id_o;
  logic [cache_pkg::data_width-1:0] resp_data_o;
  logic miss_v_o;
  logic [cache_pkg::id_width-1:0] miss_id_o;
  logic [cache_pkg::addr_width-1:0] miss_addr_o;
  cache_pkg::req_op_e miss_op_o;
  logic [$clog2(cache_pkg::ways)-1:0] miss_way_o;
  logic miss_dirty_o;
  logic miss_yumi_i;

  vector_t vectors[$];
  resp_exp_t resp_q[$];
  miss_exp_t miss_q[$];
  resp_exp_t resp_head;
  miss_exp_t miss_head;
  logic pops_held;
  logic running;
  logic loaded;
  logic [31:0] rnd_state;
  int errors;
  int checks;
  int cycles;
  int cycle_limit;

  cache_top dut (.*);

  initial clk_i = 1'b0;
  always #20 clk_i = ~clk_i;

  function automatic logic [31:0] next_random(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Fail at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
    end
  endtask

  // lines that do not start with a hex field, such as comments, are skipped
  task automatic load_vectors(output logic ok);
    int fd;
    int count;
    logic [8*200-1:0] line;
    logic [31:0] f [13];
    vector_t vec;
    ok = 1'b0;
    fd = $fopen("tb/cache_vectors.txt", "r");
    if (fd != 0) begin
      ok = 1'b1;
      while ($fgets(line, fd) != 0) begin
        count = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2],
                        f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11], f[12]);
        if (count == 13) begin
          vec = '{f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
                  {f[12], f[11], f[10], f[9]}};
          vectors.push_back(vec);
        end else if (count > 0) begin
          errors++;
          $display("malformed vector line was skipped: %0s", line);
        end
      end
      $fclose(fd);
    end
  endtask

  // starts at a rising edge and returns at the rising edge that accepted the request
  task automatic drive_vector(input vector_t vec);
    int refused;
    logic accepted;
    resp_exp_t r;
    miss_exp_t m;
    if (vec.pop != 0 && !pops_held) begin
      // a held group starts from an empty miss FIFO
      #5 v_i = 1'b0;
      while (miss_q.size() != 0)
        @(negedge clk_i);
      @(posedge clk_i);
    end
    pops_held = (vec.pop != 0);
    #5;
    v_i = 1'b1;
    op_i = cache_pkg::req_op_e'(vec.op[2:0]);
    id_i = vec.id[cache_pkg::id_width-1:0];
    addr_i = vec.addr[cache_pkg::addr_width-1:0];
    size_i = cache_pkg::size_e'(vec.size[1:0]);
    sigext_i = vec.sigext[0];
    data_i = vec.data;
    mask_i = vec.mask[cache_pkg::mask_width-1:0];
    refused = 0;
    accepted = 1'b0;
    while (!accepted) begin
      @(negedge clk_i);
      if (ready_o) begin
        accepted = 1'b1;
        if (vec.kind == 1 || vec.kind == 2) begin
          for (int k = 0; k < ((vec.kind == 2) ? 4 : 1); k++) begin
            r.id = id_i;
            r.data = vec.exp[k];
            resp_q.push_back(r);
          end
        end else if (vec.kind == 3) begin
          m.id = id_i;
          m.addr = addr_i;
          m.op = vec.op[2:0];
          m.way = vec.exp[0][0];
          m.dirty = vec.exp[1][0];
          miss_q.push_back(m);
        end
      end else begin
        refused++;
        // after a few refused cycles the misses may drain again
        if (vec.pop == 2 && refused == 4)
          pops_held = 1'b0;
      end
      @(posedge clk_i);
    end
    if (vec.pop == 2)
      check_value("ready_o stall on full miss FIFO", refused >= 4, 1);
  endtask

  always begin
    @(posedge clk_i);
    #5;
    if (running) begin
      if (resp_v_o) begin
        if (resp_q.size() == 0) begin
          errors++;
          $display("unexpected response with id %h at %0t ns", resp_id_o, $time);
        end else begin
          resp_head = resp_q.pop_front();
          check_value("resp_id_o", resp_id_o, resp_head.id);
          check_value("resp_data_o", resp_data_o, resp_head.data);
        end
      end
      rnd_state = next_random(rnd_state);
      if (miss_v_o && !pops_held && rnd_state[0]) begin
        miss_yumi_i = 1'b1;
        if (miss_q.size() == 0) begin
          errors++;
          $display("unexpected miss entry with id %h at %0t ns", miss_id_o, $time);
        end else begin
          miss_head = miss_q.pop_front();
          check_value("miss_id_o", miss_id_o, miss_head.id);
          check_value("miss_addr_o", miss_addr_o, miss_head.addr);
          check_value("miss_op_o", miss_op_o, miss_head.op);
          check_value("miss_way_o", miss_way_o, miss_head.way);
          check_value("miss_dirty_o", miss_dirty_o, miss_head.dirty);
        end
      end else begin
        miss_yumi_i = 1'b0;
      end
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("timeout, the run did not finish within %0d cycles", cycle_limit);
      $display("%0d checks, %0d errors", checks, errors);
      $display("Test failed");
      $finish;
    end
  end

  initial begin
    reset_i = 1'b1;
    v_i = 1'b0;
    op_i = cache_pkg::op_ld;
    id_i = '0;
    addr_i = '0;
    size_i = cache_pkg::size_word;
    sigext_i = 1'b0;
    data_i = '0;
    mask_i = '0;
    miss_yumi_i = 1'b0;
    pops_held = 1'b0;
    running = 1'b0;
    rnd_state = 32'h7c66;
    errors = 0;
    checks = 0;
    cycles = 0;
    load_vectors(loaded);
    cycle_limit = 20 * (vectors.size() + cache_mem_pkg::miss_fifo_depth);
    if (!loaded) begin
      $display("the vector file tb/cache_vectors.txt could not be opened");
      $display("Test failed");
      $finish;
    end else begin
      repeat (2) @(posedge clk_i);
      #5 reset_i = 1'b0;
      @(negedge clk_i);
      check_value("ready_o", ready_o, 1);
      check_value("resp_v_o", resp_v_o, 0);
      check_value("miss_v_o", miss_v_o, 0);
      running = 1'b1;
      @(posedge clk_i);
      foreach (vectors[i])
        drive_vector(vectors[i]);
      pops_held = 1'b0;
      #5 v_i = 1'b0;
      while (resp_q.size() != 0 || miss_q.size() != 0)
        @(negedge clk_i);
      // a few idle cycles catch stray responses or miss entries
      repeat (6) @(posedge clk_i);
      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0)
        $display("Test passed");
      else
        $display("Test failed");
      $finish;
    end
  end

endmodule

/* tb/cache_vectors.txt */
# columns, all hex: op id addr size sigext data mask pop kind exp0 exp1 exp2 exp3
# op 0 ld 1 st 2 block ld 3 tag st, size 0 byte 1 half 2 word, pop 0 free 1 held 2 stall
# kind 0 none 1 response 2 four responses 3 miss with exp0 way and exp1 dirty
3 0 0010 2 0 80000012 0 0 0 0 0 0 0
3 0 0110 2 0 80000034 0 0 0 0 0 0 0
1 1 1210 2 0 deadbeef f 0 0 0 0 0 0
0 2 1210 2 0 00000000 0 0 1 deadbeef 0 0 0
1 3 3414 2 0 01234567 f 0 0 0 0 0 0
0 4 3414 2 0 00000000 0 0 1 01234567 0 0 0
1 5 1218 2 0 11223344 f 0 0 0 0 0 0
1 6 1218 2 0 0000aa00 2 0 0 0 0 0 0
1 7 121a 2 0 f0000000 8 0 0 0 0 0 0
0 8 1219 0 1 00000000 0 0 1 ffffffaa 0 0 0
0 9 1219 0 0 00000000 0 0 1 000000aa 0 0 0
0 a 121a 1 1 00000000 0 0 1 fffff022 0 0 0
0 b 121a 1 0 00000000 0 0 1 0000f022 0 0 0
0 c 1218 0 1 00000000 0 0 1 00000044 0 0 0
0 d 1218 2 0 00000000 0 0 1 f022aa44 0 0 0
0 e 1218 1 1 00000000 0 0 1 ffffaa44 0 0 0
0 f 121b 0 1 00000000 0 0 1 fffffff0 0 0 0
1 1 3410 2 0 a0a0a0a0 f 0 0 0 0 0 0
1 2 3418 2 0 b1b1b1b1 f 0 0 0 0 0 0
1 3 341c 2 0 c2c2c2c2 f 0 0 0 0 0 0
2 4 3410 2 0 00000000 0 0 2 a0a0a0a0 01234567 b1b1b1b1 c2c2c2c2
0 5 1210 2 0 00000000 0 0 1 deadbeef 0 0 0
0 6 5614 2 0 00000000 0 0 3 1 1 0 0
1 7 7720 2 0 12345678 f 0 3 0 0 0 0
3 0 0120 2 0 8000009a 0 0 0 0 0 0 0
1 8 9a24 2 0 55667788 f 0 0 0 0 0 0
0 9 7720 2 0 00000000 0 0 3 0 0 0 0
3 0 0030 2 0 800000bc 0 0 0 0 0 0 0
1 a bc30 2 0 0badf00d f 0 0 0 0 0 0
3 0 0130 2 0 800000de 0 0 0 0 0 0 0
0 b bc30 2 0 00000000 0 0 1 0badf00d 0 0 0
0 c f034 2 0 00000000 0 0 3 1 0 0 0
1 d de38 2 0 13572468 f 0 0 0 0 0 0
0 e f03c 2 0 00000000 0 0 3 0 1 0 0
3 0 0130 2 0 000000de 0 0 0 0 0 0 0
0 f de38 2 0 00000000 0 0 3 0 1 0 0
0 1 2040 2 0 00000000 0 1 3 0 0 0 0
1 2 2144 2 0 99999999 f 1 3 0 0 0 0
2 3 2250 2 0 00000000 0 1 3 0 0 0 0
0 4 2354 2 0 00000000 0 1 3 0 0 0 0
0 5 2460 2 0 00000000 0 1 3 0 0 0 0
0 6 2570 2 0 00000000 0 2 3 0 0 0 0
0 7 1218 2 0 00000000 0 0 1 f022aa44 0 0 0
2 8 3410 2 0 00000000 0 0 2 a0a0a0a0 01234567 b1b1b1b1 c2c2c2c2
0 9 bc30 2 0 00000000 0 0 1 0badf00d 0 0 0
0 a 7810 2 0 00000000 0 0 3 0 1 0 0
0 b 883c 2 0 00000000 0 0 3 1 1 0 0

/* src.f */
source/cache_pkg.sv
source/cache_mem_pkg.sv
source/cache_tag_mem.sv
source/cache_stat_mem.sv
source/cache_data_mem.sv
source/cache_miss_fifo.sv
source/cache_tl_stage.sv
source/cache_top.sv
tb/cache_tb.sv

/* Bender.yml */
package:
  name: cache_front_end

sources:
  - files:
      - source/cache_pkg.sv
      - source/cache_mem_pkg.sv
      - source/cache_tag_mem.sv
      - source/cache_stat_mem.sv
      - source/cache_data_mem.sv
      - source/cache_miss_fifo.sv
      - source/cache_tl_stage.sv
      - source/cache_top.sv
  - target: simulation
    files:
      - tb/cache_tb.sv
